// File: sim.f
source/pop_pkg.sv
source/pop_cen.sv
source/pop_loader.sv
source/pop_rom.sv
source/pop_vtiming.sv
source/pop_colmix.sv
source/pop_game.sv
sim/pop_game_tb.sv

// File: sim/pop_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pop_game_tb;

    import pop_pkg::*;

    // Small video timing for a short run
    localparam int HTOT = 24;
    localparam int HACT = 16;
    localparam int HS0  = 18;
    localparam int HS1  = 20;
    localparam int VTOT = 12;
    localparam int VACT = 8;
    localparam int VS0  = 9;
    localparam int VS1  = 10;
    localparam int HOLD = 4;

    logic              clk = 1'b0;
    logic              rst;
    logic              cpu_cen, pxl_cen, pxl2_cen;
    logic              downloading;
    logic [21:0]       ioctl_addr;
    logic              ioctl_wr;
    logic [7:0]        ioctl_data;
    logic              game_rst;
    logic              rom_cs;
    logic [ROM_AW-1:0] rom_addr;
    logic [7:0]        rom_data;
    logic              rom_ok;
    logic [7:0]        pxl_idx;
    logic [9:0]        hcnt;
    logic [8:0]        vcnt;
    logic              hb, vb, hs, vs;
    logic [2:0]        red, green;
    logic [1:0]        blue;

    integer seed;
    int     mismatches;
    int     failures;
    string  test_name;

    // Reference model state
    logic [7:0]        rom_m [0:(1 << ROM_AW) - 1];
    logic [7:0]        pal_m [0:(1 << PAL_AW) - 1];
    logic [ROM_AW-1:0] rom_addrs [$];   // Addresses written during the download
    int                n;               // Clocks since reset
    int                m_h, m_v;
    int                hold_left;
    bit                exp_cpu, exp_pxl, exp_pxl2;
    bit                exp_hb, exp_vb, exp_hs, exp_vs;
    bit                exp_grst, exp_ok;
    logic [7:0]        exp_rgb, exp_rdata;
    bit                wr_pend;
    logic [21:0]       wr_addr;
    logic [7:0]        wr_data;

    // Period counters fed from the DUT flags
    bit hs_q, vs_q, line_seen, frame_seen;
    int line_pxl, hs_pxl, hb_pxl, frame_lines, vb_lines;

    pop_game #(
        .HOLD_CYCLES ( HOLD ),
        .H_TOTAL     ( HTOT ),
        .H_ACTIVE    ( HACT ),
        .HS_START    ( HS0  ),
        .HS_END      ( HS1  ),
        .V_TOTAL     ( VTOT ),
        .V_ACTIVE    ( VACT ),
        .VS_START    ( VS0  ),
        .VS_END      ( VS1  )
    ) UUT (.*);

    always #2 clk = ~clk;  // 4 ns period

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatches++;
            $display("mismatch %s %s: expected %0h, actual %0h at %0t",
                     test_name, what, expected, actual, $time);
        end
    endtask

    task automatic write_byte(input logic [21:0] addr, input logic [7:0] data);
        @(negedge clk);
        ioctl_addr = addr;
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
    endtask

    // Drops downloading and counts clocks until the game is released
    task automatic wait_release(output int cycles, output bit done);
        @(negedge clk);
        downloading = 1'b0;
        cycles = 0;
        done   = 1'b1;
        for (int i = 0; i < 64; i++) begin
            @(negedge clk);
            cycles++;
            if (!game_rst) return;
        end
        done = 1'b0;
        failures++;
        $display("Timeout: game_rst never fell after the download ended");
    endtask

    task automatic drain_reads(output bit done);
        done = 1'b1;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            rom_cs = 1'b0;
            if (rom_ok) return;
        end
        done = 1'b0;
        failures++;
        $display("Timeout: rom_ok never came for the last ROM request");
    endtask

    task automatic finish_run;
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // Model steps just after each rising edge while the inputs still hold
    always @(posedge clk) begin
        bit old_pxl;
        #1;
        if (rst) begin
            old_pxl   = 1'b0;
            n         = 0;
            {exp_cpu, exp_pxl, exp_pxl2} = 3'b000;
            {exp_hb, exp_vb, exp_hs, exp_vs} = 4'b0000;
            m_h       = 0;
            m_v       = 0;
            exp_rgb   = 8'd0;
            exp_ok    = 1'b0;
            exp_grst  = 1'b1;
            hold_left = 0;
            wr_pend   = 1'b0;
            {hs_q, vs_q, line_seen, frame_seen} = 4'b0000;
        end else begin
            old_pxl = exp_pxl;  // Enable seen by the blocks at this edge
            exp_ok  = rom_cs;
            if (rom_cs) exp_rdata = rom_m[rom_addr];
            if (old_pxl) exp_rgb = (exp_hb || exp_vb) ? 8'd0 : pal_m[pxl_idx];
            // Byte accepted last edge lands in memory now
            if (wr_pend) begin
                if (wr_addr < PAL_BASE) rom_m[wr_addr[ROM_AW-1:0]] = wr_data;
                else if (wr_addr < PAL_BASE + 256) pal_m[wr_addr[7:0]] = wr_data;
            end
            wr_pend = ioctl_wr && downloading;
            wr_addr = ioctl_addr;
            wr_data = ioctl_data;
            // Released on the HOLD-th edge that sees downloading low
            if (downloading) begin
                exp_grst  = 1'b1;
                hold_left = HOLD;
            end else if (hold_left > 0) begin
                hold_left--;
                if (hold_left == 0) exp_grst = 1'b0;
            end
            if (old_pxl) begin
                if (m_h == HTOT - 1) begin
                    m_h = 0;
                    m_v = (m_v == VTOT - 1) ? 0 : m_v + 1;
                end else begin
                    m_h++;
                end
                exp_hb = m_h >= HACT;
                exp_hs = (m_h >= HS0) && (m_h < HS1);
                exp_vb = m_v >= VACT;
                exp_vs = (m_v >= VS0) && (m_v < VS1);
            end
            n++;
            exp_pxl2 = (n % 2) == 0;  // Periods 2, 4 and 8
            exp_pxl  = (n % 4) == 0;
            exp_cpu  = (n % 8) == 0;
        end

        check_value("cpu_cen", exp_cpu, cpu_cen);
        check_value("pxl_cen", exp_pxl, pxl_cen);
        check_value("pxl2_cen", exp_pxl2, pxl2_cen);
        check_value("game_rst", exp_grst, game_rst);
        check_value("hcnt", m_h, hcnt);
        check_value("vcnt", m_v, vcnt);
        check_value("hb", exp_hb, hb);
        check_value("vb", exp_vb, vb);
        check_value("hs", exp_hs, hs);
        check_value("vs", exp_vs, vs);
        check_value("red", exp_rgb[7:5], red);
        check_value("green", exp_rgb[4:2], green);
        check_value("blue", exp_rgb[1:0], blue);
        check_value("rom_ok", exp_ok, rom_ok);
        if (exp_ok) check_value("rom_data", exp_rdata, rom_data);
        assert (!pxl_cen || pxl2_cen) else begin
            failures++;
            $display("pxl_cen pulsed without pxl2_cen at %0t", $time);
        end

        // Line and frame shape in pixel and line units
        if (!rst && old_pxl) begin
            if (vs && !vs_q) begin
                if (frame_seen) begin
                    check_value("frame lines", VTOT, frame_lines);
                    check_value("vb lines", VTOT - VACT, vb_lines);
                end
                frame_seen  = 1'b1;
                frame_lines = 0;
                vb_lines    = 0;
            end
            if (hs && !hs_q) begin
                if (line_seen) begin
                    check_value("line pixels", HTOT, line_pxl);
                    check_value("hs pixels", HS1 - HS0, hs_pxl);
                    check_value("hb pixels", HTOT - HACT, hb_pxl);
                end
                line_seen = 1'b1;
                line_pxl  = 0;
                hs_pxl    = 0;
                hb_pxl    = 0;
                frame_lines++;
                if (vb) vb_lines++;
            end
            line_pxl++;
            if (hs) hs_pxl++;
            if (hb) hb_pxl++;
            hs_q = hs;
            vs_q = vs;
        end
    end

    initial begin
        int                cycles;
        logic [ROM_AW-1:0] a;
        bit                done;
        rst         = 1'b1;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        rom_cs      = 1'b0;
        rom_addr    = '0;
        pxl_idx     = '0;
        seed        = 32'h08b41441;
        mismatches  = 0;
        failures    = 0;
        test_name   = "reset";
        begin : tests
            repeat (4) @(negedge clk);
            rst = 1'b0;
            repeat (32) @(negedge clk);

            test_name = "download";
            @(negedge clk);
            downloading = 1'b1;
            for (int i = 0; i < 200; i++) begin
                a = $random(seed);
                rom_addrs.push_back(a);
                write_byte({7'd0, a}, $random(seed));
            end
            for (int i = 0; i < 256; i++) write_byte(PAL_BASE + i, $random(seed));
            // Bytes above the palette alias ROM addresses in their low bits
            for (int i = 0; i < 4; i++) write_byte({7'd2, rom_addrs[i]}, $random(seed));
            wait_release(cycles, done);
            if (!done) disable tests;
            check_value("release delay", HOLD, cycles);

            test_name = "reload";
            @(negedge clk);
            downloading = 1'b1;
            @(negedge clk);
            assert (game_rst === 1'b1) else begin
                failures++;
                $display("game_rst did not rise with the second download");
            end
            for (int i = 0; i < 2; i++) begin
                a = $random(seed);
                rom_addrs.push_back(a);
                write_byte({7'd0, a}, $random(seed));
            end
            wait_release(cycles, done);
            if (!done) disable tests;
            check_value("release delay", HOLD, cycles);

            test_name = "rom_read";
            for (int i = 0; i < 120; i++) begin
                @(negedge clk);
                rom_cs   = ($random(seed) % 3) != 0;  // Mostly back to back
                rom_addr = rom_addrs[$unsigned($random(seed)) % rom_addrs.size()];
            end
            @(negedge clk);
            rom_cs   = 1'b1;
            rom_addr = rom_addrs[0];
            drain_reads(done);
            if (!done) disable tests;

            test_name = "video";
            for (int i = 0; i < 2400; i++) begin  // A bit over two frames
                @(negedge clk);
                pxl_idx = $random(seed);
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: source/pop_cen.sv
`timescale 1ns/1ps
`default_nettype none

module pop_cen (
    input  logic clk,      // 20 MHz
    input  logic rst,
    output logic cpu_cen,  // clk/8
    output logic pxl_cen,  // clk/4
    output logic pxl2_cen  // clk/2
);

    logic [2:0] cnt;

    // Enables decoded from the count before the increment, so
    // each one is registered and lands one clock later
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= 3'd0;
            cpu_cen  <= 1'b0;
            pxl_cen  <= 1'b0;
            pxl2_cen <= 1'b0;
        end else begin
            cnt      <= cnt + 3'd1;  // Wraps freely
            pxl2_cen <= cnt[0];
            pxl_cen  <= &cnt[1:0];
            cpu_cen  <= &cnt;
        end
    end

    // Slower enables are nested inside the faster ones
    assert property (@(posedge clk) disable iff (rst) pxl_cen |-> pxl2_cen)
        else $error("pxl_cen pulsed without pxl2_cen");

endmodule

`default_nettype wire

// File: source/pop_colmix.sv
`timescale 1ns/1ps
`default_nettype none

module pop_colmix (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    // Palette download
    input  logic [pop_pkg::PAL_AW-1:0] prog_addr,
    input  logic [7:0]                 prog_data,
    input  logic                       pal_we,
    // Pixel in
    input  logic [7:0]                 pxl_idx,
    input  logic                       hb,
    input  logic                       vb,
    // 3/3/2 colour out
    output logic [2:0]                 red,
    output logic [2:0]                 green,
    output logic [1:0]                 blue
);

    import pop_pkg::*;

    logic [7:0] pal [0:(1 << PAL_AW) - 1];
    logic [7:0] pal_rd;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal[prog_addr] <= prog_data;
        end
    end

    assign pal_rd = pal[pxl_idx];  // Asynchronous lookup

    // Black while either blanking is active
    always_ff @(posedge clk) begin
        if (rst) begin
            {red, green, blue} <= 8'd0;
        end else if (pxl_cen) begin
            {red, green, blue} <= (hb || vb) ? 8'd0 : pal_rd;
        end
    end

endmodule

`default_nettype wire

// File: source/pop_game.sv
`timescale 1ns/1ps
`default_nettype none

module pop_game #(
    parameter int HOLD_CYCLES = pop_pkg::HOLD_CYCLES,
    parameter int H_TOTAL     = pop_pkg::H_TOTAL,
    parameter int H_ACTIVE    = pop_pkg::H_ACTIVE,
    parameter int HS_START    = pop_pkg::HS_START,
    parameter int HS_END      = pop_pkg::HS_END,
    parameter int V_TOTAL     = pop_pkg::V_TOTAL,
    parameter int V_ACTIVE    = pop_pkg::V_ACTIVE,
    parameter int VS_START    = pop_pkg::VS_START,
    parameter int VS_END      = pop_pkg::VS_END
) (
    input  logic                       clk,         // 20 MHz
    input  logic                       rst,
    output logic                       cpu_cen,
    output logic                       pxl_cen,     // Pixel clock
    output logic                       pxl2_cen,    // Double pixel clock
    // ROM download
    input  logic                       downloading,
    input  logic [21:0]                ioctl_addr,
    input  logic                       ioctl_wr,
    input  logic [7:0]                 ioctl_data,
    output logic                       game_rst,
    // CPU ROM port
    input  logic                       rom_cs,
    input  logic [pop_pkg::ROM_AW-1:0] rom_addr,
    output logic [7:0]                 rom_data,
    output logic                       rom_ok,
    // Video
    input  logic [7:0]                 pxl_idx,
    output logic [9:0]                 hcnt,
    output logic [8:0]                 vcnt,
    output logic                       hb,
    output logic                       vb,
    output logic                       hs,
    output logic                       vs,
    output logic [2:0]                 red,
    output logic [2:0]                 green,
    output logic [1:0]                 blue
);

    import pop_pkg::*;

    logic [ROM_AW-1:0] prog_addr;
    logic [7:0]        prog_data;
    logic              rom_we;
    logic              pal_we;

    pop_cen u_cen (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cpu_cen  ( cpu_cen  ),  // For the external CPU
        .pxl_cen  ( pxl_cen  ),
        .pxl2_cen ( pxl2_cen )
    );

    pop_loader #(
        .HOLD_CYCLES ( HOLD_CYCLES )
    ) u_loader (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .rom_we      ( rom_we      ),
        .pal_we      ( pal_we      ),
        .game_rst    ( game_rst    )
    );

    pop_rom u_rom (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .rom_we    ( rom_we    ),
        .rom_cs    ( rom_cs    ),
        .rom_addr  ( rom_addr  ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    )
    );

    pop_vtiming #(
        .H_TOTAL  ( H_TOTAL  ),
        .H_ACTIVE ( H_ACTIVE ),
        .HS_START ( HS_START ),
        .HS_END   ( HS_END   ),
        .V_TOTAL  ( V_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .VS_START ( VS_START ),
        .VS_END   ( VS_END   )
    ) u_vtiming (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .pxl_cen ( pxl_cen ),
        .hcnt    ( hcnt    ),
        .vcnt    ( vcnt    ),
        .hb      ( hb      ),
        .vb      ( vb      ),
        .hs      ( hs      ),
        .vs      ( vs      )
    );

    pop_colmix u_colmix (
        .clk       ( clk                   ),
        .rst       ( rst                   ),
        .pxl_cen   ( pxl_cen               ),
        .prog_addr ( prog_addr[PAL_AW-1:0] ),  // Palette offset inside the region
        .prog_data ( prog_data             ),
        .pal_we    ( pal_we                ),
        .pxl_idx   ( pxl_idx               ),
        .hb        ( hb                    ),
        .vb        ( vb                    ),
        .red       ( red                   ),
        .green     ( green                 ),
        .blue      ( blue                  )
    );

endmodule

`default_nettype wire

// File: source/pop_loader.sv
`timescale 1ns/1ps
`default_nettype none

module pop_loader #(
    parameter int HOLD_CYCLES = pop_pkg::HOLD_CYCLES
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      downloading,
    input  logic                      ioctl_wr,
    input  logic [21:0]               ioctl_addr,
    input  logic [7:0]                ioctl_data,
    output logic [pop_pkg::ROM_AW-1:0] prog_addr,
    output logic [7:0]                prog_data,
    output logic                      rom_we,
    output logic                      pal_we,
    output logic                      game_rst
);

    import pop_pkg::*;

    localparam int HW = (HOLD_CYCLES > 1) ? $clog2(HOLD_CYCLES + 1) : 1;

    localparam logic [21:0] PAL_LO = 22'(PAL_BASE);
    localparam logic [21:0] PAL_HI = 22'(PAL_BASE + (1 << PAL_AW));

    load_state_t   state;
    logic [HW-1:0] hold_cnt;
    logic          wr_ok;
    logic          is_rom;
    logic          is_pal;

    assign wr_ok  = ioctl_wr && downloading;
    assign is_rom = ioctl_addr < PAL_LO;
    assign is_pal = !is_rom && (ioctl_addr < PAL_HI);  // Above PAL_HI is dropped

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ld_idle;
            hold_cnt <= '0;
        end else begin
            case (state)
                ld_idle, ld_run: begin
                    if (downloading) state <= ld_load;
                end
                ld_load: begin
                    if (!downloading) begin
                        state    <= (HOLD_CYCLES > 1) ? ld_hold : ld_run;
                        hold_cnt <= HW'(HOLD_CYCLES - 2);  // Edge into the hold counts as one
                    end
                end
                ld_hold: begin
                    if (downloading) begin
                        state <= ld_load;  // Reload restarts the sequence
                    end else if (hold_cnt == '0) begin
                        state <= ld_run;
                    end else begin
                        hold_cnt <= hold_cnt - 1'b1;
                    end
                end
                default: state <= ld_idle;
            endcase
        end
    end

    assign game_rst = (state != ld_run);

    // Write strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            rom_we <= 1'b0;
            pal_we <= 1'b0;
        end else begin
            rom_we <= wr_ok && is_rom;
            pal_we <= wr_ok && is_pal;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            prog_addr <= ioctl_addr[ROM_AW-1:0];  // Low bits also index the palette
            prog_data <= ioctl_data;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(rom_we && pal_we))
        else $error("ROM and palette written in the same cycle");

endmodule

`default_nettype wire

// File: source/pop_pkg.sv
`default_nettype none

package pop_pkg;

    // Memory map of the download stream
    localparam int ROM_AW   = 15;       // 32 KB program ROM
    localparam int PAL_AW   = 8;        // 256 palette entries
    localparam int PAL_BASE = 32768;    // Palette follows the ROM

    // Game reset held after the download ends
    localparam int HOLD_CYCLES = 4;

    // Default video timing, pixels per line
    localparam int H_TOTAL  = 320;
    localparam int H_ACTIVE = 256;
    localparam int HS_START = 272;
    localparam int HS_END   = 296;

    // Lines per frame
    localparam int V_TOTAL  = 264;
    localparam int V_ACTIVE = 224;
    localparam int VS_START = 236;
    localparam int VS_END   = 240;

    typedef enum logic [1:0] {
        ld_idle,    // Out of reset, nothing loaded yet
        ld_load,    // Download in progress
        ld_hold,    // Settling delay before release
        ld_run      // Game running
    } load_state_t;

endpackage

`default_nettype wire

// File: source/pop_rom.sv
`timescale 1ns/1ps
`default_nettype none

module pop_rom (
    input  logic                       clk,
    input  logic                       rst,
    // Download side
    input  logic [pop_pkg::ROM_AW-1:0] prog_addr,
    input  logic [7:0]                 prog_data,
    input  logic                       rom_we,
    // CPU side
    input  logic                       rom_cs,
    input  logic [pop_pkg::ROM_AW-1:0] rom_addr,
    output logic [7:0]                 rom_data,
    output logic                       rom_ok
);

    import pop_pkg::*;

    logic [7:0] mem [0:(1 << ROM_AW) - 1];

    always_ff @(posedge clk) begin
        if (rom_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Read returns the old byte on a same-address write
    always_ff @(posedge clk) begin
        if (rom_cs) begin
            rom_data <= mem[rom_addr];
        end
    end

    // One cycle latency, a request may come every clock
    always_ff @(posedge clk) begin
        if (rst) begin
            rom_ok <= 1'b0;
        end else begin
            rom_ok <= rom_cs;
        end
    end

endmodule

`default_nettype wire

// File: source/pop_vtiming.sv
`timescale 1ns/1ps
`default_nettype none

module pop_vtiming #(
    parameter int H_TOTAL  = pop_pkg::H_TOTAL,
    parameter int H_ACTIVE = pop_pkg::H_ACTIVE,
    parameter int HS_START = pop_pkg::HS_START,
    parameter int HS_END   = pop_pkg::HS_END,
    parameter int V_TOTAL  = pop_pkg::V_TOTAL,
    parameter int V_ACTIVE = pop_pkg::V_ACTIVE,
    parameter int VS_START = pop_pkg::VS_START,
    parameter int VS_END   = pop_pkg::VS_END
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    output logic [9:0] hcnt,
    output logic [8:0] vcnt,
    output logic       hb,
    output logic       vb,
    output logic       hs,
    output logic       vs
);

    logic [9:0] h_nxt;
    logic [8:0] v_nxt;
    logic       h_wrap;

    assign h_wrap = (hcnt == 10'(H_TOTAL - 1));
    assign h_nxt  = h_wrap ? 10'd0 : hcnt + 10'd1;

    always_comb begin
        v_nxt = vcnt;
        if (h_wrap) begin
            v_nxt = (vcnt == 9'(V_TOTAL - 1)) ? 9'd0 : vcnt + 9'd1;
        end
    end

    // Flags decoded from the next count so they move with the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= 10'd0;
            vcnt <= 9'd0;
            hb   <= 1'b0;
            vb   <= 1'b0;
            hs   <= 1'b0;
            vs   <= 1'b0;
        end else if (pxl_cen) begin
            hcnt <= h_nxt;
            vcnt <= v_nxt;
            hb   <= h_nxt >= 10'(H_ACTIVE);
            hs   <= (h_nxt >= 10'(HS_START)) && (h_nxt < 10'(HS_END));
            vb   <= v_nxt >= 9'(V_ACTIVE);
            vs   <= (v_nxt >= 9'(VS_START)) && (v_nxt < 9'(VS_END));
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (hcnt < 10'(H_TOTAL)) && (vcnt < 9'(V_TOTAL)))
        else $error("Video counter out of range");

endmodule

`default_nettype wire
